/* dv/pdp8_boot_memory_checker.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RIM loader protocol checker
// Handshake and halt assertions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module pdp8_boot_memory_checker (
    input logic clk,
    input logic rst,
    input logic ldr_req,
    input logic ldr_ack,
    input logic halt,
    input logic boot_done
);
    timeunit 1ns;
    timeprecision 100ps;

    // Four-phase rule, a new request waits for ack low
    a_req_after_ack: assert property (@(posedge clk) disable iff (rst)
        $rose(ldr_req) |-> !ldr_ack)
        else $error("loader raised req while ack was still high");

    // Loader handshake finishes before the CPU is released
    a_ack_needs_halt: assert property (@(posedge clk) disable iff (rst)
        ldr_ack |-> halt)
        else $error("loader ack seen without halt");

    // Done pulse comes together with halt falling
    a_done_with_halt_fall: assert property (@(posedge clk) disable iff (rst)
        boot_done |-> $fell(halt))
        else $error("boot_done high without halt falling");

endmodule

bind rim_loader pdp8_boot_memory_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .ldr_req   (ldr_req),
    .ldr_ack   (ldr_ack),
    .halt      (halt),
    .boot_done (boot_done)
);

/* dv/pdp8_boot_memory_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PDP-8 boot memory testbench
// Directed boot and CPU port tests
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pdp8_settings.svh"

module pdp8_boot_memory_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import pdp8_pkg::*;

    // Three boots plus 82 CPU accesses, 8 cycles each is generous
    localparam int NUM_BOOTS      = 3;
    localparam int NUM_ACCESSES   = 82;
    localparam int CYCLES_PER_OP  = 8;
    localparam int TIMEOUT_CYCLES = NUM_BOOTS * `PDP8_RIM_LEN * CYCLES_PER_OP
                                  + NUM_ACCESSES * CYCLES_PER_OP + 200;
    localparam logic [31:0] LFSR_SEED = 32'hed03;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int NUM_RAND = 16;

    logic   clk;
    logic   rst;
    logic   boot;
    logic   rim_high_speed;
    logic   halt;
    logic   boot_done;
    logic   cpu_req;
    logic   cpu_we;
    field_t cpu_field;
    word_t  cpu_addr;
    word_t  cpu_wdata;
    logic   cpu_ack;
    word_t  cpu_rdata;

    int          mismatch_count;
    int          other_count;
    int          cycles = 0;
    logic [31:0] lfsr_state;
    // Set when a CPU handshake saw the boot_done pulse
    logic        done_seen;
    // Random words and where they were written
    word_t       rand_data [NUM_RAND];
    word_t       rand_addr [NUM_RAND];
    field_t      rand_field [NUM_RAND];

    pdp8_boot_memory UUT (
        .clk            (clk),
        .rst            (rst),
        .boot           (boot),
        .rim_high_speed (rim_high_speed),
        .halt           (halt),
        .boot_done      (boot_done),
        .cpu_req        (cpu_req),
        .cpu_we         (cpu_we),
        .cpu_field      (cpu_field),
        .cpu_addr       (cpu_addr),
        .cpu_wdata      (cpu_wdata),
        .cpu_ack        (cpu_ack),
        .cpu_rdata      (cpu_rdata)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    // One LFSR step per bit of the word
    task automatic rand_word(output word_t w);
        w = '0;
        for (int b = 0; b < 12; b++) begin
            w = {w[10:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s got %o expected %o", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Four-phase CPU access, entered and left on a falling edge
    task automatic handshake(input logic we, input field_t fld, input word_t addr,
                             input word_t wdata, output word_t rdata);
        cpu_we    = we;
        cpu_field = fld;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cpu_req   = 1'b1;
        do begin
            @(negedge clk);
            if (boot_done === 1'b1) begin
                done_seen = 1'b1;
            end
        end while (cpu_ack !== 1'b1);
        // Read data is valid while ack is high
        rdata   = cpu_rdata;
        cpu_req = 1'b0;
        do @(negedge clk); while (cpu_ack !== 1'b0);
    endtask

    task automatic cpu_write(input field_t fld, input word_t addr, input word_t data);
        word_t unused;
        handshake(1'b1, fld, addr, data, unused);
    endtask

    task automatic cpu_read(input field_t fld, input word_t addr, output word_t data);
        handshake(1'b0, fld, addr, '0, data);
    endtask

    task automatic read_expect(input field_t fld, input word_t addr, input word_t exp);
        word_t got;
        cpu_read(fld, addr, got);
        check_word($sformatf("cpu_rdata[%0d:%o]", fld, addr), got, exp);
    endtask

    // Pulse boot, halt must follow on the next edge, then wait for done
    task automatic do_boot(input logic hs);
        boot           = 1'b1;
        rim_high_speed = hs;
        @(negedge clk);
        boot = 1'b0;
        check_bit("halt", halt, 1'b1);
        do @(negedge clk); while (boot_done !== 1'b1);
        check_bit("halt", halt, 1'b0);
    endtask

    task automatic check_image(input logic hs);
        for (int i = 0; i < `PDP8_RIM_LEN; i++) begin
            read_expect(field_t'(0), RIM_ORIGIN + word_t'(i),
                        hs ? RIM_HIGH_SPEED[i] : RIM_LOW_SPEED[i]);
        end
    endtask

    task automatic check_reset_state();
        check_bit("halt", halt, 1'b0);
        check_bit("boot_done", boot_done, 1'b0);
        check_bit("cpu_ack", cpu_ack, 1'b0);
    endtask

    // Field 1 at the loader addresses, field 0 well below them
    task automatic test_random_fill();
        word_t w;
        for (int i = 0; i < NUM_RAND; i++) begin
            rand_word(w);
            rand_data[i] = w;
            if (i < NUM_RAND / 2) begin
                rand_field[i] = field_t'(1);
                rand_addr[i]  = RIM_ORIGIN + word_t'(i);
            end else begin
                rand_field[i] = field_t'(0);
                rand_addr[i]  = 12'o1000 + word_t'(i);
            end
            cpu_write(rand_field[i], rand_addr[i], w);
        end
        check_randoms();
    endtask

    task automatic check_randoms();
        for (int i = 0; i < NUM_RAND; i++) begin
            read_expect(rand_field[i], rand_addr[i], rand_data[i]);
        end
    endtask

    // CPU write held off by the boot, acked only once it ends
    task automatic test_write_during_boot();
        word_t w;
        word_t unused;
        rand_word(w);
        done_seen      = 1'b0;
        boot           = 1'b1;
        rim_high_speed = 1'b0;
        @(negedge clk);
        boot = 1'b0;
        check_bit("halt", halt, 1'b1);
        handshake(1'b1, field_t'(0), 12'o0017, w, unused);
        if (!done_seen) begin
            other_count++;
            $display("Error at %0t: CPU write was acked before boot_done", $time);
        end
        read_expect(field_t'(0), 12'o0017, w);
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        boot           = 1'b0;
        rim_high_speed = 1'b0;
        cpu_req        = 1'b0;
        cpu_we         = 1'b0;
        cpu_field      = '0;
        cpu_addr       = '0;
        cpu_wdata      = '0;
        lfsr_state     = LFSR_SEED;
        mismatch_count = 0;
        other_count    = 0;
        done_seen      = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        check_reset_state();
        do_boot(1'b0);
        check_image(1'b0);
        test_random_fill();
        // Later boot must leave the random words alone
        do_boot(1'b1);
        check_image(1'b1);
        check_randoms();
        test_write_during_boot();

        $display("Errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* hdl/core_field.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One 4K x 12 core memory field
// with a four-phase req/ack port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module core_field (
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic        we,
    input  logic [11:0] addr,
    input  logic [11:0] wdata,
    output logic        ack,
    output logic [11:0] rdata
);

    localparam int DEPTH = 4096;

    logic [11:0] mem [DEPTH];
    // Rising edge of the handshake, ack not yet given
    logic        start;

    assign start = req && !ack;

    // Ack tracks req one edge later
    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    // Access happens on the same edge that raises ack
    always_ff @(posedge clk) begin
        if (start && we) begin
            mem[addr] <= wdata;
        end
        // Read word stays valid while ack is high
        if (start && !we) begin
            rdata <= mem[addr];
        end
    end

endmodule

/* hdl/mem_request_router.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory request router
// Grants the bus to loader or CPU
// and steers requests to a field
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pdp8_settings.svh"

module mem_request_router #(
    parameter int NUM_FIELDS = `PDP8_NUM_FIELDS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  halt,
    // Loader master, always writes field 0
    input  logic                  ldr_req,
    input  pdp8_pkg::word_t       ldr_addr,
    input  pdp8_pkg::word_t       ldr_wdata,
    output logic                  ldr_ack,
    // CPU master
    input  logic                  cpu_req,
    input  logic                  cpu_we,
    input  pdp8_pkg::field_t      cpu_field,
    input  pdp8_pkg::word_t       cpu_addr,
    input  pdp8_pkg::word_t       cpu_wdata,
    output logic                  cpu_ack,
    // Merged ack from all fields
    input  logic                  mem_ack,
    // Field side
    output logic [NUM_FIELDS-1:0] fld_req,
    output logic                  fld_we,
    output pdp8_pkg::word_t       fld_addr,
    output pdp8_pkg::word_t       fld_wdata,
    output pdp8_pkg::field_t      fld_sel
);
    import pdp8_pkg::*;

    logic grant_ldr;
    logic cpu_go;
    logic req_mux;
    logic bus_idle;

    // CPU request held back during a boot
    // An already acked CPU handshake is let through to finish
    assign cpu_go   = cpu_req && (!halt || mem_ack);
    assign req_mux  = grant_ldr ? ldr_req : cpu_go;
    // Both phases of the handshake complete
    assign bus_idle = !req_mux && !mem_ack;

    // Grant follows halt, but only across an idle bus
    always_ff @(posedge clk) begin
        if (rst) begin
            grant_ldr <= 1'b0;
        end else if (bus_idle) begin
            grant_ldr <= halt;
        end
    end

    // Steering muxes
    assign fld_we    = grant_ldr ? 1'b1 : cpu_we;
    assign fld_addr  = grant_ldr ? ldr_addr : cpu_addr;
    assign fld_wdata = grant_ldr ? ldr_wdata : cpu_wdata;
    assign fld_sel   = grant_ldr ? field_t'(0) : cpu_field;

    // One-hot request to the addressed field
    always_comb begin
        for (int i = 0; i < NUM_FIELDS; i++) begin
            fld_req[i] = req_mux && (fld_sel == field_t'(i));
        end
    end

    // Ack goes back to the granted master only
    assign ldr_ack = grant_ldr && mem_ack;
    assign cpu_ack = !grant_ldr && mem_ack;

endmodule

/* hdl/mem_response_merge.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response merge for all fields
// ORs the acks, picks read data
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pdp8_settings.svh"

module mem_response_merge #(
    parameter int NUM_FIELDS = `PDP8_NUM_FIELDS
) (
    input  pdp8_pkg::field_t      fld_sel,
    input  logic [NUM_FIELDS-1:0] fld_ack,
    input  pdp8_pkg::word_t       fld_rdata [NUM_FIELDS],
    output logic                  mem_ack,
    output pdp8_pkg::word_t       mem_rdata
);
    import pdp8_pkg::*;

    // Only one field is ever requested at a time
    assign mem_ack = |fld_ack;

    // Data mux on the field number
    // A field number beyond the array reads as zero
    always_comb begin
        mem_rdata = '0;
        for (int i = 0; i < NUM_FIELDS; i++) begin
            if (fld_sel == field_t'(i)) begin
                mem_rdata = fld_rdata[i];
            end
        end
    end

endmodule

/* hdl/pdp8_boot_memory.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PDP-8 boot memory subsystem
// RIM loader, router, core fields
// and response merge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pdp8_settings.svh"

module pdp8_boot_memory (
    input  logic             clk,
    input  logic             rst,
    input  logic             boot,
    input  logic             rim_high_speed,
    output logic             halt,
    output logic             boot_done,
    // Processor port
    input  logic             cpu_req,
    input  logic             cpu_we,
    input  pdp8_pkg::field_t cpu_field,
    input  pdp8_pkg::word_t  cpu_addr,
    input  pdp8_pkg::word_t  cpu_wdata,
    output logic             cpu_ack,
    output pdp8_pkg::word_t  cpu_rdata
);
    import pdp8_pkg::*;

    localparam int NUM_FIELDS = `PDP8_NUM_FIELDS;

    // Loader to router
    logic                  ldr_req;
    logic                  ldr_ack;
    word_t                 ldr_addr;
    word_t                 ldr_wdata;
    // Router to fields, shared lines plus one req per field
    logic [NUM_FIELDS-1:0] fld_req;
    logic                  fld_we;
    word_t                 fld_addr;
    word_t                 fld_wdata;
    field_t                fld_sel;
    // Fields to merge
    logic [NUM_FIELDS-1:0] fld_ack;
    word_t                 fld_rdata [NUM_FIELDS];
    logic                  mem_ack;
    word_t                 mem_rdata;

    rim_loader u_loader (
        .clk            (clk),
        .rst            (rst),
        .boot           (boot),
        .rim_high_speed (rim_high_speed),
        .ldr_ack        (ldr_ack),
        .ldr_req        (ldr_req),
        .ldr_addr       (ldr_addr),
        .ldr_wdata      (ldr_wdata),
        .halt           (halt),
        .boot_done      (boot_done)
    );

    mem_request_router #(
        .NUM_FIELDS (NUM_FIELDS)
    ) u_router (
        .clk       (clk),
        .rst       (rst),
        .halt      (halt),
        .ldr_req   (ldr_req),
        .ldr_addr  (ldr_addr),
        .ldr_wdata (ldr_wdata),
        .ldr_ack   (ldr_ack),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_field (cpu_field),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_ack   (cpu_ack),
        .mem_ack   (mem_ack),
        .fld_req   (fld_req),
        .fld_we    (fld_we),
        .fld_addr  (fld_addr),
        .fld_wdata (fld_wdata),
        .fld_sel   (fld_sel)
    );

    // Field array, all fields share address and data lines
    for (genvar i = 0; i < NUM_FIELDS; i++) begin : g_field
        core_field u_field (
            .clk   (clk),
            .rst   (rst),
            .req   (fld_req[i]),
            .we    (fld_we),
            .addr  (fld_addr),
            .wdata (fld_wdata),
            .ack   (fld_ack[i]),
            .rdata (fld_rdata[i])
        );
    end

    mem_response_merge #(
        .NUM_FIELDS (NUM_FIELDS)
    ) u_merge (
        .fld_sel   (fld_sel),
        .fld_ack   (fld_ack),
        .fld_rdata (fld_rdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    // Only the CPU ever reads, so the data goes straight back
    assign cpu_rdata = mem_rdata;

endmodule

/* hdl/pdp8_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PDP-8 shared types and the two
// DEC RIM loader images
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pdp8_settings.svh"

package pdp8_pkg;

    // One machine word, also an address within a field
    typedef logic [11:0] word_t;
    // Memory field number, up to eight fields
    typedef logic [2:0] field_t;

    // First loader address in field 0
    localparam word_t RIM_ORIGIN = 12'o7756;

    // Teletype reader variant (KCC/KSF/KRB/KRS)
    localparam word_t RIM_LOW_SPEED [`PDP8_RIM_LEN] = '{
        12'o6032, 12'o6031, 12'o5357, 12'o6036,
        12'o7106, 12'o7006, 12'o7510, 12'o5357,
        12'o7006, 12'o6031, 12'o5367, 12'o6034,
        12'o7420, 12'o3776, 12'o3376, 12'o5356
    };

    // Paper tape reader variant (RFC/RSF/RRB)
    localparam word_t RIM_HIGH_SPEED [`PDP8_RIM_LEN] = '{
        12'o6014, 12'o6011, 12'o5357, 12'o6016,
        12'o7106, 12'o7006, 12'o7510, 12'o5374,
        12'o7006, 12'o6011, 12'o5367, 12'o6016,
        12'o7420, 12'o3776, 12'o3376, 12'o5357
    };

endpackage

/* hdl/pdp8_settings.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PDP-8 boot memory build settings
// Field count and RIM loader size
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef PDP8_SETTINGS_SVH
`define PDP8_SETTINGS_SVH

// Number of 4K core fields
// Any value from 1 to 8 is supported
`define PDP8_NUM_FIELDS 2

// Words in the RIM loader image
// Addresses 7756..7775 octal
`define PDP8_RIM_LEN 16

`endif

/* hdl/rim_loader.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RIM loader boot sequencer
// Halts the CPU and writes the RIM
// image into field 0 at 7756..7775
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pdp8_settings.svh"

module rim_loader (
    input  logic            clk,
    input  logic            rst,
    input  logic            boot,
    input  logic            rim_high_speed,
    input  logic            ldr_ack,
    output logic            ldr_req,
    output pdp8_pkg::word_t ldr_addr,
    output pdp8_pkg::word_t ldr_wdata,
    output logic            halt,
    output logic            boot_done
);
    import pdp8_pkg::*;

    // Index value that ends the sequence
    localparam logic [4:0] LAST_IDX = 5'(`PDP8_RIM_LEN);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_DONE
    } state_t;

    state_t     state;
    // Word index, one bit wider than the table so it can reach 16
    logic [4:0] idx;
    // Image choice, held for the whole boot
    logic       hs_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            idx    <= '0;
            hs_sel <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // Only an idle loader accepts a boot pulse
                    if (boot) begin
                        hs_sel <= rim_high_speed;
                        idx    <= '0;
                        state  <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    // Word is written, drop req and step to the next one
                    if (ldr_ack) begin
                        idx   <= idx + 5'd1;
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    // Four-phase rule, no new req until ack is low
                    if (!ldr_ack) begin
                        if (idx == LAST_IDX) begin
                            state <= ST_DONE;
                        end else begin
                            state <= ST_REQ;
                        end
                    end
                end
                default: begin
                    // ST_DONE lasts one cycle
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Request is held for the whole REQ state
    assign ldr_req   = (state == ST_REQ);
    // CPU stays halted until the last ack has fallen
    assign halt      = (state == ST_REQ) || (state == ST_WAIT);
    // One cycle pulse, coincides with halt falling
    assign boot_done = (state == ST_DONE);

    // Address and data stay stable while req is high
    assign ldr_addr  = RIM_ORIGIN + {7'd0, idx};
    assign ldr_wdata = hs_sel ? RIM_HIGH_SPEED[idx[3:0]] : RIM_LOW_SPEED[idx[3:0]];

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the PDP-8 boot memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        -f verilog.f --top-module pdp8_boot_memory_tb -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_tb)"
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

/* verilog.f */
+incdir+hdl
hdl/pdp8_pkg.sv
hdl/rim_loader.sv
hdl/mem_request_router.sv
hdl/core_field.sv
hdl/mem_response_merge.sv
hdl/pdp8_boot_memory.sv
dv/pdp8_boot_memory_checker.sv
dv/pdp8_boot_memory_tb.sv
